/* design/dma_defines.svh */
// width, depth and backend count macros of the DMA subsystem
// shared by the packages, RTL and testbench

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// word address into the on-chip memory
`define DMA_ADDR_W 8
// one data word
`define DMA_DATA_W 32
// copy backends, 1, 2, 4 or 8
`define DMA_NUM_BE 4
// memory depth in words
`define DMA_MEM_WORDS 256
// transfer length in words, 0 to 256
`define DMA_LEN_W 9
// byte address width of both APB ports
`define DMA_APB_AW 12

`endif

/* design/dma_reg_pkg.sv */
// register map of the frontend APB block
// byte offsets and STATUS bit positions

`include "dma_defines.svh"

package dma_reg_pkg;

  // byte offsets, one 32-bit word per register
  typedef enum logic [`DMA_APB_AW-1:0] {
    REG_SRC     = 'h00,
    REG_DST     = 'h04,
    REG_LEN     = 'h08,
    REG_NEXT_ID = 'h0C,
    REG_STATUS  = 'h10
  } reg_off_e;

  // STATUS fields
  localparam int unsigned STAT_IDLE_BIT = 0;
  localparam int unsigned STAT_DONE_BIT = 1;

endpackage

/* design/dma_xfer_pkg.sv */
// copy datapath types
// backend states plus address, word and length vectors

`include "dma_defines.svh"

package dma_xfer_pkg;

  typedef logic [`DMA_ADDR_W-1:0] word_addr_t;
  typedef logic [`DMA_DATA_W-1:0] word_t;
  typedef logic [`DMA_LEN_W-1:0]  len_t;

  // backend engine states
  typedef enum logic {
    BE_IDLE = 1'b0,
    BE_COPY = 1'b1
  } be_state_e;

endpackage

/* design/dma_frontend.sv */
// APB register block of the DMA
// descriptor registers, id counter, sticky done flag and launch pulse

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_frontend (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [`DMA_APB_AW-1:0]   paddr_i,
  input  logic [`DMA_DATA_W-1:0]   pwdata_i,
  output logic [`DMA_DATA_W-1:0]   prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  input  logic                     idle_i,
  input  logic                     complete_i,
  output logic                     launch_o,
  output dma_xfer_pkg::word_addr_t src_o,
  output dma_xfer_pkg::word_addr_t dst_o,
  output dma_xfer_pkg::len_t       len_o,
  output logic [31:0]              id_o
);

  import dma_reg_pkg::*;
  import dma_xfer_pkg::*;

  // host-programmed descriptor
  word_addr_t  src_q;
  word_addr_t  dst_q;
  len_t        len_q;
  // id handed out by the next launch
  logic [31:0] next_id_q;
  logic        done_q;
  logic        access;
  logic        launch_ok;
  logic        rd_launch;
  reg_off_e    off;

  // access phase of a zero-wait transfer
  assign access   = psel_i & penable_i;
  assign off      = reg_off_e'(paddr_i);
  assign pready_o = 1'b1;

  // a launch already in flight counts as busy
  assign launch_ok = idle_i & ~launch_o;
  assign rd_launch = access & ~pwrite_i & (off == REG_NEXT_ID) & launch_ok;

  // read mux and error decode
  always_comb begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    case (off)
      REG_SRC: prdata_o = `DMA_DATA_W'(src_q);
      REG_DST: prdata_o = `DMA_DATA_W'(dst_q);
      REG_LEN: prdata_o = `DMA_DATA_W'(len_q);
      REG_NEXT_ID: begin
        // busy reads return 0, host retries
        prdata_o  = launch_ok ? `DMA_DATA_W'(next_id_q) : '0;
        pslverr_o = pwrite_i;
      end
      REG_STATUS: begin
        prdata_o[STAT_IDLE_BIT] = idle_i;
        prdata_o[STAT_DONE_BIT] = done_q;
        pslverr_o               = pwrite_i;
      end
      default: pslverr_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q     <= '0;
      dst_q     <= '0;
      len_q     <= '0;
      next_id_q <= 32'd1;
      done_q    <= 1'b0;
      launch_o  <= 1'b0;
    end else begin
      launch_o <= rd_launch;
      // launch beats a completion in the same cycle
      if (launch_o) begin
        done_q <= 1'b0;
      end else if (complete_i) begin
        done_q <= 1'b1;
      end
      if (rd_launch) begin
        next_id_q <= next_id_q + 32'd1;
      end
      // descriptor writes, read-only registers ignore the data
      if (access && pwrite_i) begin
        case (off)
          REG_SRC: src_q <= pwdata_i[`DMA_ADDR_W-1:0];
          REG_DST: dst_q <= pwdata_i[`DMA_ADDR_W-1:0];
          REG_LEN: len_q <= pwdata_i[`DMA_LEN_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // snapshot of the launched descriptor, held until the next launch
  always_ff @(posedge clk_i) begin
    if (rd_launch) begin
      src_o <= src_q;
      dst_o <= dst_q;
      len_o <= len_q;
      id_o  <= next_id_q;
    end
  end

endmodule

/* design/dma_splitter.sv */
// word-interleaved transfer splitter
// per-backend chunk descriptors, start pulses and active mask

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_splitter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     launch_i,
  input  dma_xfer_pkg::word_addr_t src_i,
  input  dma_xfer_pkg::word_addr_t dst_i,
  input  dma_xfer_pkg::len_t       len_i,
  output logic [`DMA_NUM_BE-1:0]   start_o,
  output dma_xfer_pkg::word_addr_t chunk_src_o [`DMA_NUM_BE],
  output dma_xfer_pkg::word_addr_t chunk_dst_o [`DMA_NUM_BE],
  output dma_xfer_pkg::len_t       chunk_cnt_o [`DMA_NUM_BE],
  output logic                     xfer_start_o,
  output logic [`DMA_NUM_BE-1:0]   active_mask_o
);

  import dma_xfer_pkg::*;

  len_t                   cnt_d [`DMA_NUM_BE];
  logic [`DMA_NUM_BE-1:0] mask_d;
  logic [`DMA_NUM_BE-1:0] mask_q;
  logic                   xfer_q;

  // backend k takes words k, k+N, ... below len
  // count is ceil((len-k)/N), zero when len <= k
  always_comb begin
    for (int k = 0; k < `DMA_NUM_BE; k++) begin
      if (len_i > len_t'(k)) begin
        cnt_d[k] = (len_i - len_t'(k) + len_t'(`DMA_NUM_BE - 1)) / len_t'(`DMA_NUM_BE);
      end else begin
        cnt_d[k] = '0;
      end
      mask_d[k] = (cnt_d[k] != '0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xfer_q <= 1'b0;
      mask_q <= '0;
    end else begin
      xfer_q <= launch_i;
      if (launch_i) begin
        mask_q <= mask_d;
      end
    end
  end

  // chunk descriptors, valid from the start pulse on
  always_ff @(posedge clk_i) begin
    if (launch_i) begin
      for (int k = 0; k < `DMA_NUM_BE; k++) begin
        chunk_src_o[k] <= src_i + word_addr_t'(k);
        chunk_dst_o[k] <= dst_i + word_addr_t'(k);
        chunk_cnt_o[k] <= cnt_d[k];
      end
    end
  end

  // only backends with work see a start
  assign start_o       = mask_q & {`DMA_NUM_BE{xfer_q}};
  assign xfer_start_o  = xfer_q;
  assign active_mask_o = mask_q;

endmodule

/* design/dma_backend.sv */
// single copy engine
// moves a strided chunk of words, one read and one write per cycle

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_backend #(
  parameter int unsigned BE_IDX = 0
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  dma_xfer_pkg::word_addr_t src_i,
  input  dma_xfer_pkg::word_addr_t dst_i,
  input  dma_xfer_pkg::len_t       cnt_i,
  output dma_xfer_pkg::word_addr_t rd_addr_o,
  input  dma_xfer_pkg::word_t      rd_data_i,
  output logic                     we_o,
  output dma_xfer_pkg::word_addr_t wr_addr_o,
  output dma_xfer_pkg::word_t      wr_data_o,
  output logic                     done_o
);

  import dma_xfer_pkg::*;

  // interleave stride between words of one chunk
  localparam word_addr_t STRIDE = word_addr_t'(`DMA_NUM_BE);

  be_state_e  state_q;
  word_addr_t rd_ptr_q;
  word_addr_t wr_ptr_q;
  // words still to copy
  len_t       left_q;
  logic       last;

  // memory read is combinational, data goes straight to the write port
  assign rd_addr_o = rd_ptr_q;
  assign wr_addr_o = wr_ptr_q;
  assign wr_data_o = rd_data_i;
  assign we_o      = (state_q == BE_COPY);
  assign last      = (left_q == len_t'(1));
  // done rides along with the final write
  assign done_o    = we_o & last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= BE_IDLE;
      // idle pointers park on this lane's first word
      rd_ptr_q <= word_addr_t'(BE_IDX);
      wr_ptr_q <= word_addr_t'(BE_IDX);
      left_q   <= '0;
    end else begin
      case (state_q)
        BE_IDLE: begin
          if (start_i && (cnt_i != '0)) begin
            rd_ptr_q <= src_i;
            wr_ptr_q <= dst_i;
            left_q   <= cnt_i;
            state_q  <= BE_COPY;
          end
        end
        BE_COPY: begin
          rd_ptr_q <= rd_ptr_q + STRIDE;
          wr_ptr_q <= wr_ptr_q + STRIDE;
          left_q   <= left_q - len_t'(1);
          if (last) begin
            state_q <= BE_IDLE;
          end
        end
        default: state_q <= BE_IDLE;
      endcase
    end
  end

endmodule

/* design/dma_completion.sv */
// completion tracker
// pending mask of started backends, merged complete pulse and idle flag

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_completion (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   launch_i,
  input  logic                   xfer_start_i,
  input  logic [`DMA_NUM_BE-1:0] active_mask_i,
  input  logic [`DMA_NUM_BE-1:0] done_i,
  output logic                   complete_o,
  output logic                   idle_o
);

  logic [`DMA_NUM_BE-1:0] pending_q;
  logic [`DMA_NUM_BE-1:0] pending_d;
  // waiting for the pending mask to drain
  logic                   armed_q;
  logic                   busy_q;
  logic                   fire;

  // start loads the mask, done pulses knock bits out
  always_comb begin
    if (xfer_start_i) begin
      pending_d = active_mask_i & ~done_i;
    end else begin
      pending_d = pending_q & ~done_i;
    end
  end

  // an empty mask at start (len 0) completes right away
  assign fire = (xfer_start_i | armed_q) & (pending_d == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q  <= '0;
      armed_q    <= 1'b0;
      busy_q     <= 1'b0;
      complete_o <= 1'b0;
    end else begin
      pending_q  <= pending_d;
      complete_o <= fire;
      if (fire) begin
        armed_q <= 1'b0;
      end else if (xfer_start_i) begin
        armed_q <= 1'b1;
      end
      // busy from launch, ahead of the splitter start, until completion
      if (launch_i) begin
        busy_q <= 1'b1;
      end else if (fire) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign idle_o = ~busy_q;

endmodule

/* design/dma_mem.sv */
// on-chip word memory of the DMA
// one read and one write port per backend plus a zero-wait APB host port

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_mem (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [`DMA_APB_AW-1:0]   paddr_i,
  input  logic [`DMA_DATA_W-1:0]   pwdata_i,
  output logic [`DMA_DATA_W-1:0]   prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  input  dma_xfer_pkg::word_addr_t rd_addr_i [`DMA_NUM_BE],
  output dma_xfer_pkg::word_t      rd_data_o [`DMA_NUM_BE],
  input  logic [`DMA_NUM_BE-1:0]   we_i,
  input  dma_xfer_pkg::word_addr_t wr_addr_i [`DMA_NUM_BE],
  input  dma_xfer_pkg::word_t      wr_data_i [`DMA_NUM_BE]
);

  import dma_xfer_pkg::*;

  word_t                   mem_q [`DMA_MEM_WORDS];
  // host word index, byte address over 4
  logic [`DMA_APB_AW-3:0]  host_idx;
  word_addr_t              host_addr;
  logic                    host_oob;
  logic                    host_we;

  assign host_idx  = paddr_i[`DMA_APB_AW-1:2];
  assign host_addr = host_idx[`DMA_ADDR_W-1:0];
  assign host_oob  = (host_idx >= (`DMA_APB_AW-2)'(`DMA_MEM_WORDS));
  assign host_we   = psel_i & penable_i & pwrite_i & ~host_oob;

  // zero wait, error past the depth
  assign pready_o  = 1'b1;
  assign pslverr_o = host_oob;
  assign prdata_o  = host_oob ? '0 : mem_q[host_addr];

  // combinational backend reads
  always_comb begin
    for (int k = 0; k < `DMA_NUM_BE; k++) begin
      rd_data_o[k] = mem_q[rd_addr_i[k]];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `DMA_MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (host_we) begin
        mem_q[host_addr] <= pwdata_i;
      end
      // backend writes come last and override a host write to the same word
      for (int k = 0; k < `DMA_NUM_BE; k++) begin
        if (we_i[k]) begin
          mem_q[wr_addr_i[k]] <= wr_data_i[k];
        end
      end
    end
  end

endmodule

/* design/dma_top.sv */
// DMA subsystem top level
// frontend, splitter, backend array, completion tracker and memory

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // register port
  input  logic                   cfg_psel_i,
  input  logic                   cfg_penable_i,
  input  logic                   cfg_pwrite_i,
  input  logic [`DMA_APB_AW-1:0] cfg_paddr_i,
  input  logic [`DMA_DATA_W-1:0] cfg_pwdata_i,
  output logic [`DMA_DATA_W-1:0] cfg_prdata_o,
  output logic                   cfg_pready_o,
  output logic                   cfg_pslverr_o,
  // memory host port
  input  logic                   mem_psel_i,
  input  logic                   mem_penable_i,
  input  logic                   mem_pwrite_i,
  input  logic [`DMA_APB_AW-1:0] mem_paddr_i,
  input  logic [`DMA_DATA_W-1:0] mem_pwdata_i,
  output logic [`DMA_DATA_W-1:0] mem_prdata_o,
  output logic                   mem_pready_o,
  output logic                   mem_pslverr_o
);

  import dma_xfer_pkg::*;

  // launched descriptor
  logic                   launch;
  word_addr_t             src;
  word_addr_t             dst;
  len_t                   len;
  logic                   idle;
  logic                   complete;
  // splitter to backends and tracker
  logic [`DMA_NUM_BE-1:0] be_start;
  word_addr_t             chunk_src [`DMA_NUM_BE];
  word_addr_t             chunk_dst [`DMA_NUM_BE];
  len_t                   chunk_cnt [`DMA_NUM_BE];
  logic                   xfer_start;
  logic [`DMA_NUM_BE-1:0] active_mask;
  // backend memory ports
  word_addr_t             be_rd_addr [`DMA_NUM_BE];
  word_t                  be_rd_data [`DMA_NUM_BE];
  logic [`DMA_NUM_BE-1:0] be_we;
  word_addr_t             be_wr_addr [`DMA_NUM_BE];
  word_t                  be_wr_data [`DMA_NUM_BE];
  logic [`DMA_NUM_BE-1:0] be_done;

  dma_frontend dma_frontend_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .psel_i     (cfg_psel_i),
    .penable_i  (cfg_penable_i),
    .pwrite_i   (cfg_pwrite_i),
    .paddr_i    (cfg_paddr_i),
    .pwdata_i   (cfg_pwdata_i),
    .prdata_o   (cfg_prdata_o),
    .pready_o   (cfg_pready_o),
    .pslverr_o  (cfg_pslverr_o),
    .idle_i     (idle),
    .complete_i (complete),
    .launch_o   (launch),
    .src_o      (src),
    .dst_o      (dst),
    .len_o      (len),
    .id_o       ()
  );

  dma_splitter dma_splitter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .launch_i      (launch),
    .src_i         (src),
    .dst_i         (dst),
    .len_i         (len),
    .start_o       (be_start),
    .chunk_src_o   (chunk_src),
    .chunk_dst_o   (chunk_dst),
    .chunk_cnt_o   (chunk_cnt),
    .xfer_start_o  (xfer_start),
    .active_mask_o (active_mask)
  );

  // one copy engine per interleave lane
  for (genvar k = 0; k < `DMA_NUM_BE; k++) begin : g_be
    dma_backend #(
      .BE_IDX (k)
    ) dma_backend_inst (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .start_i   (be_start[k]),
      .src_i     (chunk_src[k]),
      .dst_i     (chunk_dst[k]),
      .cnt_i     (chunk_cnt[k]),
      .rd_addr_o (be_rd_addr[k]),
      .rd_data_i (be_rd_data[k]),
      .we_o      (be_we[k]),
      .wr_addr_o (be_wr_addr[k]),
      .wr_data_o (be_wr_data[k]),
      .done_o    (be_done[k])
    );
  end

  dma_completion dma_completion_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .launch_i      (launch),
    .xfer_start_i  (xfer_start),
    .active_mask_i (active_mask),
    .done_i        (be_done),
    .complete_o    (complete),
    .idle_o        (idle)
  );

  dma_mem dma_mem_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (mem_psel_i),
    .penable_i (mem_penable_i),
    .pwrite_i  (mem_pwrite_i),
    .paddr_i   (mem_paddr_i),
    .pwdata_i  (mem_pwdata_i),
    .prdata_o  (mem_prdata_o),
    .pready_o  (mem_pready_o),
    .pslverr_o (mem_pslverr_o),
    .rd_addr_i (be_rd_addr),
    .rd_data_o (be_rd_data),
    .we_i      (be_we),
    .wr_addr_i (be_wr_addr),
    .wr_data_i (be_wr_data)
  );

endmodule

/* bench/dma_tb.sv */
// directed testbench of the DMA subsystem
// APB driver tasks, reference memory model, watchdog and summary

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_tb;

  import dma_reg_pkg::*;

  localparam int CLK_PERIOD  = 100;
  // setup, access and release cycle of one APB transfer
  localparam int APB_CYCLES  = 3;
  // longest transfer, every backend busy for its whole chunk
  localparam int XFER_CYCLES = `DMA_MEM_WORDS / `DMA_NUM_BE + 8;
  // full memory fill, full memory check and one transfer
  localparam int TEST_CYCLES = 2 * `DMA_MEM_WORDS * APB_CYCLES + XFER_CYCLES;
  localparam int NUM_RUNS    = 16;
  localparam int WATCHDOG_NS = (NUM_RUNS * TEST_CYCLES + 1000) * CLK_PERIOD;
  localparam int HALF        = `DMA_MEM_WORDS / 2;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   cfg_psel_i;
  logic                   cfg_penable_i;
  logic                   cfg_pwrite_i;
  logic [`DMA_APB_AW-1:0] cfg_paddr_i;
  logic [`DMA_DATA_W-1:0] cfg_pwdata_i;
  logic [`DMA_DATA_W-1:0] cfg_prdata_o;
  logic                   cfg_pready_o;
  logic                   cfg_pslverr_o;
  logic                   mem_psel_i;
  logic                   mem_penable_i;
  logic                   mem_pwrite_i;
  logic [`DMA_APB_AW-1:0] mem_paddr_i;
  logic [`DMA_DATA_W-1:0] mem_pwdata_i;
  logic [`DMA_DATA_W-1:0] mem_prdata_o;
  logic                   mem_pready_o;
  logic                   mem_pslverr_o;

  // expected memory contents
  logic [`DMA_DATA_W-1:0] ref_mem [`DMA_MEM_WORDS];
  // id the next launch must return
  logic [31:0]            exp_id;
  int                     test_errs;
  int                     pass_count;
  int                     fail_count;
  int unsigned            seed;
  string                  cur_test;

  dma_top dma_top_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_psel_i    (cfg_psel_i),
    .cfg_penable_i (cfg_penable_i),
    .cfg_pwrite_i  (cfg_pwrite_i),
    .cfg_paddr_i   (cfg_paddr_i),
    .cfg_pwdata_i  (cfg_pwdata_i),
    .cfg_prdata_o  (cfg_prdata_o),
    .cfg_pready_o  (cfg_pready_o),
    .cfg_pslverr_o (cfg_pslverr_o),
    .mem_psel_i    (mem_psel_i),
    .mem_penable_i (mem_penable_i),
    .mem_pwrite_i  (mem_pwrite_i),
    .mem_paddr_i   (mem_paddr_i),
    .mem_pwdata_i  (mem_pwdata_i),
    .mem_prdata_o  (mem_prdata_o),
    .mem_pready_o  (mem_pready_o),
    .mem_pslverr_o (mem_pslverr_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // register port write, inputs change on the falling edge
  task automatic reg_write(input logic [`DMA_APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    @(negedge clk_i);
    cfg_psel_i    = 1'b1;
    cfg_penable_i = 1'b0;
    cfg_pwrite_i  = 1'b1;
    cfg_paddr_i   = addr;
    cfg_pwdata_i  = data;
    @(negedge clk_i);
    cfg_penable_i = 1'b1;
    #10;
    err = cfg_pslverr_o;
    // zero wait, pready high in every access phase
    if (cfg_pready_o !== 1'b1) report_mismatch("cfg pready", 32'h1, cfg_pready_o);
    @(negedge clk_i);
    cfg_psel_i    = 1'b0;
    cfg_penable_i = 1'b0;
    cfg_pwrite_i  = 1'b0;
  endtask

  // register port read, sampled mid access phase
  task automatic reg_read(input logic [`DMA_APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge clk_i);
    cfg_psel_i    = 1'b1;
    cfg_penable_i = 1'b0;
    cfg_pwrite_i  = 1'b0;
    cfg_paddr_i   = addr;
    @(negedge clk_i);
    cfg_penable_i = 1'b1;
    #10;
    data = cfg_prdata_o;
    err  = cfg_pslverr_o;
    if (cfg_pready_o !== 1'b1) report_mismatch("cfg pready", 32'h1, cfg_pready_o);
    @(negedge clk_i);
    cfg_psel_i    = 1'b0;
    cfg_penable_i = 1'b0;
  endtask

  // memory host port write, word index turned into a byte address
  task automatic mem_write(input int word, input logic [31:0] data, output logic err);
    @(negedge clk_i);
    mem_psel_i    = 1'b1;
    mem_penable_i = 1'b0;
    mem_pwrite_i  = 1'b1;
    mem_paddr_i   = `DMA_APB_AW'(word * 4);
    mem_pwdata_i  = data;
    @(negedge clk_i);
    mem_penable_i = 1'b1;
    #10;
    err = mem_pslverr_o;
    if (mem_pready_o !== 1'b1) report_mismatch("mem pready", 32'h1, mem_pready_o);
    @(negedge clk_i);
    mem_psel_i    = 1'b0;
    mem_penable_i = 1'b0;
    mem_pwrite_i  = 1'b0;
  endtask

  task automatic mem_read(input int word, output logic [31:0] data, output logic err);
    @(negedge clk_i);
    mem_psel_i    = 1'b1;
    mem_penable_i = 1'b0;
    mem_pwrite_i  = 1'b0;
    mem_paddr_i   = `DMA_APB_AW'(word * 4);
    @(negedge clk_i);
    mem_penable_i = 1'b1;
    #10;
    data = mem_prdata_o;
    err  = mem_pslverr_o;
    if (mem_pready_o !== 1'b1) report_mismatch("mem pready", 32'h1, mem_pready_o);
    @(negedge clk_i);
    mem_psel_i    = 1'b0;
    mem_penable_i = 1'b0;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL %s: %s expected 0x%h actual 0x%h", cur_test, what, exp, act);
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("PASS %s", cur_test);
      pass_count++;
    end else begin
      $display("FAIL %s with %0d errors", cur_test, test_errs);
      fail_count++;
    end
  endtask

  // fresh random words through the host port, mirrored in the model
  task automatic fill_region(input int lo, input int hi);
    logic [31:0] v;
    logic        err;
    for (int a = lo; a <= hi; a++) begin
      v = $urandom;
      mem_write(a, v, err);
      ref_mem[a] = v;
    end
  endtask

  task automatic check_region(input int lo, input int hi);
    logic [31:0] d;
    logic        err;
    for (int a = lo; a <= hi; a++) begin
      mem_read(a, d, err);
      if (d !== ref_mem[a]) report_mismatch($sformatf("mem word %0d", a), ref_mem[a], d);
    end
  endtask

  // program the descriptor and launch through a NEXT_ID read
  task automatic launch_xfer(input int src, input int dst, input int len);
    logic [31:0] id;
    logic        err;
    reg_write(REG_SRC, src, err);
    reg_write(REG_DST, dst, err);
    reg_write(REG_LEN, len, err);
    reg_read(REG_NEXT_ID, id, err);
    if (id !== exp_id) report_mismatch("launch id", exp_id, id);
    if (err !== 1'b0) report_mismatch("pslverr on NEXT_ID read", 32'h0, err);
    exp_id = exp_id + 32'd1;
  endtask

  // poll STATUS until the sticky done bit shows up
  task automatic wait_done();
    logic [31:0] st;
    logic        err;
    int          polls;
    polls = 0;
    st    = '0;
    while (!st[STAT_DONE_BIT] && polls < XFER_CYCLES) begin
      reg_read(REG_STATUS, st, err);
      polls++;
    end
    if (!st[STAT_DONE_BIT]) begin
      $display("FAIL %s: transfer did not finish within %0d status polls", cur_test, polls);
      test_errs++;
    end
  endtask

  // apply the copy to the model, check destination plus one word each side
  task automatic finish_copy(input int src, input int dst, input int len);
    int lo;
    int hi;
    wait_done();
    for (int i = 0; i < len; i++) begin
      ref_mem[dst + i] = ref_mem[src + i];
    end
    lo = (dst > 0) ? dst - 1 : 0;
    hi = (dst + len < `DMA_MEM_WORDS) ? dst + len : `DMA_MEM_WORDS - 1;
    check_region(lo, hi);
  endtask

  task automatic run_copy(input int src, input int dst, input int len);
    if (len > 0) fill_region(src, src + len - 1);
    launch_xfer(src, dst, len);
    finish_copy(src, dst, len);
  endtask

  task automatic test_reset_regs();
    logic [31:0] d;
    logic        err;
    begin_test("reset_regs");
    reg_read(REG_STATUS, d, err);
    if (d !== (32'd1 << STAT_IDLE_BIT)) begin
      report_mismatch("status after reset", 32'd1 << STAT_IDLE_BIT, d);
    end
    reg_write(REG_SRC, 32'h12, err);
    reg_write(REG_DST, 32'hc4, err);
    // bit 8 of LEN is the 256 case
    reg_write(REG_LEN, 32'h156, err);
    reg_read(REG_SRC, d, err);
    if (d !== 32'h12) report_mismatch("SRC readback", 32'h12, d);
    reg_read(REG_DST, d, err);
    if (d !== 32'hc4) report_mismatch("DST readback", 32'hc4, d);
    reg_read(REG_LEN, d, err);
    if (d !== 32'h156) report_mismatch("LEN readback", 32'h156, d);
    reg_read(12'h014, d, err);
    if (err !== 1'b1) report_mismatch("pslverr unmapped read", 32'h1, err);
    reg_write(REG_STATUS, 32'h3, err);
    if (err !== 1'b1) report_mismatch("pslverr STATUS write", 32'h1, err);
    // a NEXT_ID write must not use up an id
    reg_write(REG_NEXT_ID, 32'h7, err);
    if (err !== 1'b1) report_mismatch("pslverr NEXT_ID write", 32'h1, err);
    end_test();
  endtask

  task automatic test_basic_copy();
    begin_test("basic_copy");
    fill_region(0, `DMA_MEM_WORDS - 1);
    run_copy(16, 144, 13);
    end_test();
  endtask

  // short lengths leave some backends without a chunk
  task automatic test_lengths();
    int i;
    int len;
    int src;
    int dst;
    begin_test("lengths");
    for (i = 0; i < 8; i++) begin
      case (i)
        0: len = 1;
        1: len = 3;
        2: len = 4;
        default: len = $urandom_range(HALF, 1);
      endcase
      src = $urandom_range(HALF - len, 0);
      dst = HALF + $urandom_range(HALF - len, 0);
      run_copy(src, dst, len);
    end
    end_test();
  endtask

  task automatic test_zero_len();
    begin_test("zero_len");
    launch_xfer(32, 160, 0);
    wait_done();
    check_region(0, `DMA_MEM_WORDS - 1);
    end_test();
  endtask

  task automatic test_busy();
    logic [31:0] d;
    logic        err;
    begin_test("busy_backpressure");
    launch_xfer(0, 56, 200);
    reg_read(REG_NEXT_ID, d, err);
    if (d !== 32'h0) report_mismatch("NEXT_ID while busy", 32'h0, d);
    reg_read(REG_STATUS, d, err);
    if (d !== 32'h0) report_mismatch("status while busy", 32'h0, d);
    wait_done();
    // ranges of a 200 word copy overlap, so the contents are reloaded
    fill_region(0, `DMA_MEM_WORDS - 1);
    launch_xfer(8, 160, 4);
    reg_read(REG_STATUS, d, err);
    if (d[STAT_DONE_BIT] !== 1'b0) report_mismatch("done after launch", 32'h0, d);
    finish_copy(8, 160, 4);
    end_test();
  endtask

  task automatic test_mem_port();
    logic [31:0] d;
    logic [31:0] v;
    logic        err;
    begin_test("mem_port");
    v = $urandom;
    mem_write(37, v, err);
    ref_mem[37] = v;
    if (err !== 1'b0) report_mismatch("pslverr in range write", 32'h0, err);
    mem_read(37, d, err);
    if (d !== v) report_mismatch("host readback", v, d);
    mem_write(`DMA_MEM_WORDS, 32'hdead_beef, err);
    if (err !== 1'b1) report_mismatch("pslverr write past depth", 32'h1, err);
    mem_read(`DMA_MEM_WORDS + 5, d, err);
    if (err !== 1'b1) report_mismatch("pslverr read past depth", 32'h1, err);
    // a rejected write must not alias into the array
    check_region(0, `DMA_MEM_WORDS - 1);
    end_test();
  endtask

  initial begin
    seed          = $urandom(28648);
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    cfg_psel_i    = 1'b0;
    cfg_penable_i = 1'b0;
    cfg_pwrite_i  = 1'b0;
    cfg_paddr_i   = '0;
    cfg_pwdata_i  = '0;
    mem_psel_i    = 1'b0;
    mem_penable_i = 1'b0;
    mem_pwrite_i  = 1'b0;
    mem_paddr_i   = '0;
    mem_pwdata_i  = '0;
    exp_id        = 32'd1;
    pass_count    = 0;
    fail_count    = 0;
    test_errs     = 0;
    // memory clears at reset
    for (int a = 0; a < `DMA_MEM_WORDS; a++) begin
      ref_mem[a] = '0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_regs();
    test_basic_copy();
    test_lengths();
    test_zero_len();
    test_busy();
    test_mem_port();
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // bound on the whole run, sized from the per-test worst case
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, cur_test);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/dma_reg_pkg.sv
design/dma_xfer_pkg.sv
design/dma_frontend.sv
design/dma_splitter.sv
design/dma_backend.sv
design/dma_completion.sv
design/dma_mem.sv
design/dma_top.sv
bench/dma_tb.sv
